//--- verilog/ln_settings.svh
// Width, fraction and depth constants for the layer-norm engine
`ifndef LN_SETTINGS_SVH
`define LN_SETTINGS_SVH

// Lanes per vector, must be a power of two
`define LN_DEPTH 8

// log2 of LN_DEPTH, used for the mean and variance shifts
`define LN_DEPTH_LOG2 3

// Signed lane width and its fractional bits
`define LN_WIDTH 8
`define LN_FRAC 4

// Variance holds a squared (LN_WIDTH+1)-bit difference
`define LN_VAR_WIDTH (2 * (`LN_WIDTH + 1))

`endif

//--- verilog/ln_pkg.sv
// Lane, vector, statistics and FSM state types for the layer-norm engine
`include "ln_settings.svh"

package ln_pkg;

  // One signed input or output lane
  typedef logic signed [`LN_WIDTH-1:0] lane_t;
  typedef lane_t [`LN_DEPTH-1:0] lane_vec_t;

  // Lane minus mean needs one extra bit
  typedef logic signed [`LN_WIDTH:0] diff_t;
  typedef diff_t [`LN_DEPTH-1:0] diff_vec_t;

  // Variance in units of 2^-(2*LN_FRAC)
  typedef logic [`LN_VAR_WIDTH-1:0] var_t;

  // Standard deviation in units of 2^-LN_FRAC
  typedef logic [`LN_VAR_WIDTH/2-1:0] std_t;

  typedef enum logic [2:0] {
    IDLE,
    STATS,
    ROOT,
    NORM,
    OUT
  } ctrl_state_t;

  typedef enum logic [1:0] {
    ROOT_IDLE,
    ROOT_ITER,
    ROOT_DONE
  } root_state_t;

endpackage

//--- verilog/ln_ctrl.sv
// Sequencing FSM of the layer-norm engine with the input and output handshakes
`timescale 1ns/10ps

module ln_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  logic out_ready,
  input  logic stats_done,
  input  logic root_done,
  output logic in_ready,
  output logic out_valid,
  output logic stats_start,
  output logic root_start,
  output logic norm_start
);

  ln_pkg::ctrl_state_t state;
  ln_pkg::ctrl_state_t state_nxt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ln_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ln_pkg::IDLE: begin
        if (in_valid) begin
          state_nxt = ln_pkg::STATS;
        end
      end
      ln_pkg::STATS: begin
        if (stats_done) begin
          state_nxt = ln_pkg::ROOT;
        end
      end
      ln_pkg::ROOT: begin
        if (root_done) begin
          state_nxt = ln_pkg::NORM;
        end
      end
      // Scaling takes a single cycle
      ln_pkg::NORM: state_nxt = ln_pkg::OUT;
      ln_pkg::OUT: begin
        if (out_ready) begin
          state_nxt = ln_pkg::IDLE;
        end
      end
      default: state_nxt = ln_pkg::IDLE;
    endcase
  end

  // Only one vector in flight, so input is refused outside IDLE
  assign in_ready    = (state == ln_pkg::IDLE);
  assign stats_start = (state == ln_pkg::IDLE) && in_valid;

  // Square root starts in the cycle the variance is ready
  assign root_start = (state == ln_pkg::STATS) && stats_done;
  assign norm_start = (state == ln_pkg::NORM);

  // Result is held in ln_scale until taken
  assign out_valid = (state == ln_pkg::OUT);

endmodule

//--- verilog/ln_stats.sv
// Two-stage mean and variance unit with registered lane differences
`timescale 1ns/10ps
`include "ln_settings.svh"

module ln_stats (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stats_start,
  input  ln_pkg::lane_vec_t in_data,
  output logic              stats_done,
  output ln_pkg::diff_vec_t diff_vec,
  output ln_pkg::var_t      variance
);

  localparam int SUM_W = `LN_WIDTH + `LN_DEPTH_LOG2;
  localparam int SQ_W  = `LN_VAR_WIDTH + `LN_DEPTH_LOG2;

  logic signed [SUM_W-1:0] lane_sum;
  logic signed [SUM_W-1:0] mean_wide;
  ln_pkg::lane_t           mean;
  ln_pkg::diff_vec_t       diff_nxt;
  logic [SQ_W-1:0]         sq_sum;
  logic                    diff_valid;

  // Stage 1: mean by arithmetic shift, floor rounding
  always_comb begin
    ln_pkg::lane_t lane;
    lane_sum = '0;
    for (int i = 0; i < `LN_DEPTH; i++) begin
      lane     = in_data[i];
      lane_sum = lane_sum + lane;
    end
    mean_wide = lane_sum >>> `LN_DEPTH_LOG2;
    mean      = mean_wide[`LN_WIDTH-1:0];
    for (int i = 0; i < `LN_DEPTH; i++) begin
      lane        = in_data[i];
      diff_nxt[i] = lane - mean;
    end
  end

  // Stage 2: sum of squares over the registered differences
  always_comb begin
    ln_pkg::diff_t d;
    ln_pkg::var_t  sq;
    sq_sum = '0;
    for (int i = 0; i < `LN_DEPTH; i++) begin
      d      = diff_vec[i];
      sq     = d * d;
      sq_sum = sq_sum + sq;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      diff_valid <= 1'b0;
      stats_done <= 1'b0;
    end else begin
      diff_valid <= stats_start;
      stats_done <= diff_valid;
    end
  end

  // Results stay put until the next start
  always_ff @(posedge clk) begin
    if (stats_start) begin
      diff_vec <= diff_nxt;
    end
    if (diff_valid) begin
      variance <= sq_sum[SQ_W-1:`LN_DEPTH_LOG2];
    end
  end

endmodule

//--- verilog/ln_isqrt.sv
// Iterative restoring integer square root, one result bit per cycle
`timescale 1ns/10ps
`include "ln_settings.svh"

module ln_isqrt (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         root_start,
  input  ln_pkg::var_t variance,
  output logic         root_done,
  output ln_pkg::std_t std_dev
);

  localparam int ROOT_W = `LN_VAR_WIDTH / 2;
  localparam int CNT_W  = $clog2(ROOT_W);

  ln_pkg::root_state_t state;
  logic [CNT_W-1:0]    count;
  ln_pkg::var_t        radicand;
  ln_pkg::std_t        root;
  logic [ROOT_W+1:0]   rem;
  logic [ROOT_W+1:0]   rem_shift;
  logic [ROOT_W+1:0]   trial;

  // Bring down the next two radicand bits and try root*4+1
  assign rem_shift = {rem[ROOT_W-1:0], radicand[`LN_VAR_WIDTH-1 -: 2]};
  assign trial     = {root, 2'b01};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ln_pkg::ROOT_IDLE;
      count <= '0;
    end else begin
      case (state)
        ln_pkg::ROOT_IDLE: begin
          if (root_start) begin
            state <= ln_pkg::ROOT_ITER;
            count <= CNT_W'(ROOT_W - 1);
          end
        end
        ln_pkg::ROOT_ITER: begin
          if (count == '0) begin
            state <= ln_pkg::ROOT_DONE;
          end else begin
            count <= count - 1'b1;
          end
        end
        ln_pkg::ROOT_DONE: state <= ln_pkg::ROOT_IDLE;
        default:           state <= ln_pkg::ROOT_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ln_pkg::ROOT_IDLE && root_start) begin
      radicand <= variance;
      rem      <= '0;
      root     <= '0;
    end else if (state == ln_pkg::ROOT_ITER) begin
      radicand <= radicand << 2;
      if (rem_shift >= trial) begin
        rem  <= rem_shift - trial;
        root <= {root[ROOT_W-2:0], 1'b1};
      end else begin
        rem  <= rem_shift;
        root <= {root[ROOT_W-2:0], 1'b0};
      end
    end
  end

  // Root holds its floor value from DONE until the next start
  assign root_done = (state == ln_pkg::ROOT_DONE);
  assign std_dev   = root;

endmodule

//--- verilog/ln_scale.sv
// Per-lane divide, gamma multiply, beta add and saturation into the output register
`timescale 1ns/10ps
`include "ln_settings.svh"

module ln_scale (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              stats_start,
  input  logic              norm_start,
  input  ln_pkg::diff_vec_t diff_vec,
  input  ln_pkg::std_t      std_dev,
  input  ln_pkg::lane_vec_t in_gamma,
  input  ln_pkg::lane_vec_t in_beta,
  output ln_pkg::lane_vec_t out_data
);

  localparam int NUM_W  = `LN_WIDTH + 1 + `LN_FRAC;
  localparam int PROD_W = NUM_W + `LN_WIDTH;
  localparam int ACC_W  = PROD_W + 1;

  localparam logic signed [ACC_W-1:0] LANE_MAX = ACC_W'((1 << (`LN_WIDTH - 1)) - 1);
  localparam logic signed [ACC_W-1:0] LANE_MIN = -LANE_MAX - 1;

  ln_pkg::lane_vec_t gamma_q;
  ln_pkg::lane_vec_t beta_q;
  ln_pkg::lane_vec_t out_nxt;

  always_comb begin
    ln_pkg::diff_t             d;
    ln_pkg::lane_t             g;
    ln_pkg::lane_t             b;
    logic signed [`LN_VAR_WIDTH/2:0] divisor;
    logic signed [NUM_W-1:0]   num;
    logic signed [NUM_W-1:0]   quo;
    logic signed [PROD_W-1:0]  prod;
    logic signed [ACC_W-1:0]   acc;
    divisor = {1'b0, std_dev};
    for (int i = 0; i < `LN_DEPTH; i++) begin
      d   = diff_vec[i];
      g   = gamma_q[i];
      b   = beta_q[i];
      num = d <<< `LN_FRAC;
      // Signed divide truncates toward zero; zero spread gives zero
      if (std_dev == '0) begin
        quo = '0;
      end else begin
        quo = num / divisor;
      end
      prod = quo * g;
      acc  = (prod >>> `LN_FRAC) + b;
      if (acc > LANE_MAX) begin
        out_nxt[i] = LANE_MAX[`LN_WIDTH-1:0];
      end else if (acc < LANE_MIN) begin
        out_nxt[i] = LANE_MIN[`LN_WIDTH-1:0];
      end else begin
        out_nxt[i] = acc[`LN_WIDTH-1:0];
      end
    end
  end

  // Weights are taken with the data at acceptance
  always_ff @(posedge clk) begin
    if (stats_start) begin
      gamma_q <= in_gamma;
      beta_q  <= in_beta;
    end
  end

  // Output register, held while the result waits for out_ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_data <= '0;
    end else if (norm_start) begin
      out_data <= out_nxt;
    end
  end

endmodule

//--- verilog/layer_norm_top.sv
// Layer-norm engine top level with controller, statistics, square root and scaling units
`timescale 1ns/10ps

module layer_norm_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  output logic              in_ready,
  input  ln_pkg::lane_vec_t in_data,
  input  ln_pkg::lane_vec_t in_gamma,
  input  ln_pkg::lane_vec_t in_beta,
  output logic              out_valid,
  input  logic              out_ready,
  output ln_pkg::lane_vec_t out_data
);

  logic              stats_start;
  logic              stats_done;
  logic              root_start;
  logic              root_done;
  logic              norm_start;
  ln_pkg::diff_vec_t diff_vec;
  ln_pkg::var_t      variance;
  ln_pkg::std_t      std_dev;

  ln_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .out_ready   (out_ready),
    .stats_done  (stats_done),
    .root_done   (root_done),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .stats_start (stats_start),
    .root_start  (root_start),
    .norm_start  (norm_start)
  );

  // Mean, differences and variance of the accepted vector
  ln_stats u_stats (
    .clk         (clk),
    .rst_n       (rst_n),
    .stats_start (stats_start),
    .in_data     (in_data),
    .stats_done  (stats_done),
    .diff_vec    (diff_vec),
    .variance    (variance)
  );

  ln_isqrt u_isqrt (
    .clk        (clk),
    .rst_n      (rst_n),
    .root_start (root_start),
    .variance   (variance),
    .root_done  (root_done),
    .std_dev    (std_dev)
  );

  // Gamma and beta are sampled together with the data
  ln_scale u_scale (
    .clk         (clk),
    .rst_n       (rst_n),
    .stats_start (stats_start),
    .norm_start  (norm_start),
    .diff_vec    (diff_vec),
    .std_dev     (std_dev),
    .in_gamma    (in_gamma),
    .in_beta     (in_beta),
    .out_data    (out_data)
  );

endmodule

//--- verif/layer_norm_properties.sv
// Concurrent handshake assertions for the layer-norm engine and their bind to the top level
`timescale 1ns/10ps

module layer_norm_properties (
  input logic              clk,
  input logic              rst_n,
  input logic              in_ready,
  input logic              out_valid,
  input logic              out_ready,
  input ln_pkg::lane_vec_t out_data
);

  // Result stays on the bus until it is taken
  hold_output: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else $error("out_data changed or out_valid dropped before out_ready");

  // Only one vector in flight
  no_input_during_output: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !in_ready)
    else $error("in_ready high while out_valid is high");

  release_after_take: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && out_ready) |=> !out_valid)
    else $error("out_valid still high after the output was taken");

endmodule

bind layer_norm_top layer_norm_properties u_properties (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data)
);

//--- verif/layer_norm_tb.sv
// Testbench for the layer-norm engine with reference model, stimulus table and handshake checks
`timescale 1ns/10ps
`include "ln_settings.svh"

module layer_norm_tb;

  localparam int NUM_FIXED = 4;
  localparam int NUM_ROWS  = 16;
  localparam int TIMEOUT   = 100;
  localparam int LANE_MAX  = (1 << (`LN_WIDTH - 1)) - 1;
  localparam int LANE_MIN  = -(1 << (`LN_WIDTH - 1));

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  logic              in_ready;
  ln_pkg::lane_vec_t in_data;
  ln_pkg::lane_vec_t in_gamma;
  ln_pkg::lane_vec_t in_beta;
  logic              out_valid;
  logic              out_ready;
  ln_pkg::lane_vec_t out_data;

  // Stimulus table, one row per vector
  string             tbl_name[NUM_ROWS];
  ln_pkg::lane_vec_t tbl_data[NUM_ROWS];
  ln_pkg::lane_vec_t tbl_gamma[NUM_ROWS];
  ln_pkg::lane_vec_t tbl_beta[NUM_ROWS];
  ln_pkg::lane_vec_t tbl_expect[NUM_ROWS];
  int                tbl_stall[NUM_ROWS];
  bit                tbl_sat[NUM_ROWS];
  ln_pkg::lane_t     tbl_limit[NUM_ROWS];
  integer            seed;

  layer_norm_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .in_gamma  (in_gamma),
    .in_beta   (in_beta),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  always #50 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic int floor_sqrt(input int v);
    int r;
    r = 0;
    while ((r + 1) * (r + 1) <= v) begin
      r++;
    end
    return r;
  endfunction

  // Expected output vector from the fixed-point layer-norm rules
  function automatic ln_pkg::lane_vec_t model_layer_norm(input ln_pkg::lane_vec_t data,
                                                         input ln_pkg::lane_vec_t gamma,
                                                         input ln_pkg::lane_vec_t beta);
    ln_pkg::lane_t     lane;
    ln_pkg::lane_t     g;
    ln_pkg::lane_t     b;
    ln_pkg::lane_vec_t res;
    int                diff[`LN_DEPTH];
    int                sum;
    int                mean;
    int                sq_sum;
    int                sd;
    int                norm;
    int                val;
    sum = 0;
    for (int i = 0; i < `LN_DEPTH; i++) begin
      lane = data[i];
      sum  = sum + lane;
    end
    mean   = sum >>> `LN_DEPTH_LOG2;
    sq_sum = 0;
    for (int i = 0; i < `LN_DEPTH; i++) begin
      lane    = data[i];
      diff[i] = lane - mean;
      sq_sum  = sq_sum + diff[i] * diff[i];
    end
    sd = floor_sqrt(sq_sum >>> `LN_DEPTH_LOG2);
    for (int i = 0; i < `LN_DEPTH; i++) begin
      g    = gamma[i];
      b    = beta[i];
      // Integer division truncates toward zero
      norm = (sd == 0) ? 0 : (diff[i] * (1 << `LN_FRAC)) / sd;
      val  = ((norm * g) >>> `LN_FRAC) + b;
      if (val > LANE_MAX) val = LANE_MAX;
      if (val < LANE_MIN) val = LANE_MIN;
      res[i] = val[`LN_WIDTH-1:0];
    end
    return res;
  endfunction

  task automatic fill_table();
    for (int i = 0; i < `LN_DEPTH; i++) begin
      // Constant vector, zero spread, so output is beta
      tbl_data[0][i]  = 8'sd37;
      tbl_gamma[0][i] = 8'sd64;
      tbl_beta[0][i]  = ln_pkg::lane_t'(i * 13 - 50);
      // Alternating extremes at unit gamma
      tbl_data[1][i]  = i[0] ? 8'sh80 : 8'sh7f;
      tbl_gamma[1][i] = 8'sd16;
      tbl_beta[1][i]  = 8'sd0;
      // One outlier with full-scale gamma drives lane 0 into saturation
      tbl_data[2][i]  = (i == 0) ? 8'sh7f : 8'sh80;
      tbl_gamma[2][i] = 8'sh7f;
      tbl_beta[2][i]  = 8'sd100;
      tbl_data[3][i]  = (i == 0) ? 8'sh7f : 8'sh80;
      tbl_gamma[3][i] = 8'sh80;
      tbl_beta[3][i]  = -8'sd100;
    end
    tbl_name[0] = "constant";
    tbl_name[1] = "extremes";
    tbl_name[2] = "sat_high";
    tbl_name[3] = "sat_low";
    tbl_stall[0] = 2;
    tbl_stall[1] = 0;
    tbl_stall[2] = 5;
    tbl_stall[3] = 1;
    tbl_sat[0] = 1'b0;
    tbl_sat[1] = 1'b0;
    tbl_sat[2] = 1'b1;
    tbl_sat[3] = 1'b1;
    // Lane 0 sits far above the mean, so the sign of gamma picks the limit
    tbl_limit[0] = '0;
    tbl_limit[1] = '0;
    tbl_limit[2] = 8'sh7f;
    tbl_limit[3] = 8'sh80;
    for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
      tbl_name[r] = $sformatf("random_%0d", r - NUM_FIXED);
      for (int i = 0; i < `LN_DEPTH; i++) begin
        tbl_data[r][i]  = ln_pkg::lane_t'($random(seed));
        tbl_gamma[r][i] = ln_pkg::lane_t'($random(seed));
        tbl_beta[r][i]  = ln_pkg::lane_t'($random(seed));
      end
      tbl_stall[r] = $random(seed) & 32'h7;
      tbl_sat[r]   = 1'b0;
      tbl_limit[r] = '0;
    end
  endtask

  task automatic run_row(input int r);
    int                waited;
    ln_pkg::lane_vec_t held;
    waited = 0;
    while (!in_ready) begin
      @(negedge clk);
      waited++;
      assert (waited <= TIMEOUT)
        else fail_run($sformatf("Timeout in %s: in_ready never went high", tbl_name[r]));
    end
    in_valid = 1'b1;
    in_data  = tbl_data[r];
    in_gamma = tbl_gamma[r];
    in_beta  = tbl_beta[r];
    @(negedge clk);
    in_valid = 1'b0;
    waited   = 0;
    while (!out_valid) begin
      @(negedge clk);
      waited++;
      assert (waited <= TIMEOUT)
        else fail_run($sformatf("Timeout in %s: out_valid never went high", tbl_name[r]));
    end
    held = out_data;
    // Back-pressure, result must wait unchanged
    for (int c = 0; c < tbl_stall[r]; c++) begin
      @(negedge clk);
      assert (out_valid && !in_ready)
        else fail_run($sformatf("In %s the engine dropped out_valid or raised in_ready early",
                                tbl_name[r]));
      assert (out_data == held)
        else fail_run($sformatf("[ERROR] %s hold: expected %h, actual %h",
                                tbl_name[r], held, out_data));
    end
    if (tbl_sat[r]) begin
      assert (out_data[0] == tbl_limit[r])
        else fail_run($sformatf("[ERROR] %s lane 0: expected %h, actual %h",
                                tbl_name[r], tbl_limit[r], out_data[0]));
    end
    assert (out_data == tbl_expect[r])
      else fail_run($sformatf("[ERROR] %s: expected %h, actual %h",
                              tbl_name[r], tbl_expect[r], out_data));
    out_ready = 1'b1;
    @(negedge clk);
    out_ready = 1'b0;
    assert (!out_valid && in_ready)
      else fail_run($sformatf("In %s the engine did not return to idle after the output was taken",
                              tbl_name[r]));
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    in_gamma  = '0;
    in_beta   = '0;
    out_ready = 1'b0;
    seed      = 6251;
    fill_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      tbl_expect[r] = model_layer_norm(tbl_data[r], tbl_gamma[r], tbl_beta[r]);
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (in_ready && !out_valid)
      else fail_run("After reset in_ready was low or out_valid was high");
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- src.f
+incdir+verilog
verilog/ln_pkg.sv
verilog/ln_ctrl.sv
verilog/ln_stats.sv
verilog/ln_isqrt.sv
verilog/ln_scale.sv
verilog/layer_norm_top.sv
verif/layer_norm_properties.sv
verif/layer_norm_tb.sv

//--- Makefile
TOP := layer_norm_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
	  -f src.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
